/* rv_core.f */
source/rv_core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/reg_file.sv
source/mem_arbiter.sv
source/rv_core.sv
tb/tb_mem_model.sv
tb/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -Mdir obj_dir \
  && ./obj_dir/Vtb_rv_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* tb/tb_rv_core.sv */
// RV64I core testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;
  import rv_core_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int MEM_AW       = 8;
  localparam int PROG_LEN     = 24;
  // straight-line part plus a few turns of the closing self-loop
  localparam int NUM_RETIRE   = 26;
  localparam int TIMEOUT_NS   = CLK_PERIOD * (RESET_CYCLES + NUM_RETIRE * 30);

  logic            clk = 1'b0;
  logic            rst = 1'b1;
  logic            bus_req;
  bus_req_t        bus;
  logic            bus_ack;
  logic [XLEN-1:0] bus_rdata;
  logic            retire_valid;
  retire_t         retire;

  logic [XLEN-1:0] image [2**MEM_AW];
  logic [XLEN-1:0] ref_mem [2**MEM_AW];
  logic [XLEN-1:0] ref_regs [32];
  logic [XLEN-1:0] ref_pc;
  int              retired = 0;
  int              mismatches = 0;
  int              protocol_errors = 0;

  // expected outcome of the instruction at ref_pc
  logic [ILEN-1:0] inst;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] st_addr;
  logic [XLEN-1:0] exp_val;
  logic [XLEN-1:0] exp_next;
  logic            exp_wen;
  logic            exp_store;

  rv_core i_rv_core (
    .clk(clk), .i_rst(rst), .o_bus_req(bus_req), .o_bus(bus), .i_bus_ack(bus_ack),
    .i_bus_rdata(bus_rdata), .o_retire_valid(retire_valid), .o_retire(retire));

  tb_mem_model #(.AW(MEM_AW)) u_mem (
    .clk(clk), .i_rst(rst), .i_bus_req(bus_req), .i_bus(bus), .o_bus_ack(bus_ack),
    .o_bus_rdata(bus_rdata));

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [ILEN-1:0] itype(input logic [6:0] opc, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [ILEN-1:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [ILEN-1:0] stype(input logic [4:0] rs2, input logic [4:0] rs1,
      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
  endfunction

  function automatic logic [ILEN-1:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [ILEN-1:0] utype(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  function automatic logic [ILEN-1:0] jtype(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic build_image();
    logic [ILEN-1:0] prog [PROG_LEN];
    logic [XLEN-1:0] addr;
    prog[0]  = itype(7'h13, 3'b000, 5'd1, 5'd0, 12'h123);
    prog[1]  = itype(7'h13, 3'b000, 5'd2, 5'd0, 12'hffb);
    prog[2]  = rtype(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    prog[3]  = rtype(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
    prog[4]  = rtype(7'h00, 3'b111, 5'd5, 5'd1, 5'd2);
    prog[5]  = rtype(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);
    prog[6]  = rtype(7'h00, 3'b100, 5'd7, 5'd1, 5'd2);
    prog[7]  = utype(5'd8, 20'h80000);
    // x0 as destination, then x0 as source
    prog[8]  = itype(7'h13, 3'b000, 5'd0, 5'd1, 12'h007);
    prog[9]  = rtype(7'h00, 3'b000, 5'd9, 5'd0, 5'd1);
    prog[10] = itype(7'h13, 3'b000, 5'd10, 5'd0, 12'h400);
    prog[11] = stype(5'd3, 5'd10, 12'h008);
    prog[12] = itype(7'h03, 3'b011, 5'd11, 5'd10, 12'h008);
    prog[13] = itype(7'h03, 3'b011, 5'd12, 5'd10, 12'h010);
    prog[14] = btype(3'b000, 5'd11, 5'd3, 13'h008);
    prog[15] = itype(7'h13, 3'b000, 5'd13, 5'd0, 12'h001);
    prog[16] = btype(3'b001, 5'd11, 5'd3, 13'h008);
    prog[17] = btype(3'b001, 5'd1, 5'd2, 13'h008);
    prog[18] = itype(7'h13, 3'b000, 5'd13, 5'd0, 12'h002);
    prog[19] = btype(3'b000, 5'd1, 5'd2, 13'h008);
    prog[20] = jtype(5'd14, 21'h000008);
    prog[21] = itype(7'h13, 3'b000, 5'd13, 5'd0, 12'h003);
    prog[22] = rtype(7'h00, 3'b000, 5'd15, 5'd14, 5'd8);
    prog[23] = jtype(5'd0, 21'h000000);
    for (int w = 0; w < 2**MEM_AW; w++) begin
      addr     = XLEN'(w) << 3;
      image[w] = (addr * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a5a_0000_0000_c3c3;
    end
    for (int k = 0; k < PROG_LEN; k++) begin
      image[k / 2][32 * (k % 2) +: 32] = prog[k];
    end
  endtask

  always_comb begin
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] ld_addr;
    logic [2:0]      f3;
    logic            writes;
    word      = ref_mem[ref_pc[MEM_AW+2:3]];
    inst      = ref_pc[2] ? word[63:32] : word[31:0];
    f3        = inst[14:12];
    src1      = ref_regs[inst[19:15]];
    src2      = ref_regs[inst[24:20]];
    imm_i     = 64'($signed(inst[31:20]));
    imm_b     = 64'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
    imm_j     = 64'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
    st_addr   = src1 + 64'($signed({inst[31:25], inst[11:7]}));
    ld_addr   = src1 + imm_i;
    exp_next  = ref_pc + 64'd4;
    exp_val   = '0;
    exp_store = 1'b0;
    writes    = 1'b0;
    case (inst[6:0])
      7'h13: begin
        writes  = (f3 == 3'b000);
        exp_val = src1 + imm_i;
      end
      7'h33: begin
        writes = 1'b1;
        case ({inst[31:25], f3})
          {7'h00, 3'b000}: exp_val = src1 + src2;
          {7'h20, 3'b000}: exp_val = src1 - src2;
          {7'h00, 3'b100}: exp_val = src1 ^ src2;
          {7'h00, 3'b110}: exp_val = src1 | src2;
          {7'h00, 3'b111}: exp_val = src1 & src2;
          default:         writes = 1'b0;
        endcase
      end
      7'h37: begin
        writes  = 1'b1;
        exp_val = 64'($signed({inst[31:12], 12'h000}));
      end
      7'h03: begin
        writes  = (f3 == 3'b011);
        exp_val = ref_mem[ld_addr[MEM_AW+2:3]];
      end
      7'h23: exp_store = (f3 == 3'b011);
      7'h63: begin
        if ((f3 == 3'b000 && src1 == src2) || (f3 == 3'b001 && src1 != src2)) begin
          exp_next = ref_pc + imm_b;
        end
      end
      7'h6f: begin
        writes   = 1'b1;
        exp_val  = ref_pc + 64'd4;
        exp_next = ref_pc + imm_j;
      end
      default: writes = 1'b0;
    endcase
    exp_wen = writes && (inst[11:7] != 5'd0);
  end

  // reference state steps once per retired instruction
  always @(posedge clk) begin
    if (rst) begin
      ref_pc = RESET_PC;
      for (int r = 0; r < 32; r++) begin
        ref_regs[r] = '0;
      end
      for (int w = 0; w < 2**MEM_AW; w++) begin
        ref_mem[w] = image[w];
      end
    end else if (retire_valid) begin
      if (exp_wen) begin
        ref_regs[inst[11:7]] = exp_val;
      end
      if (exp_store) begin
        ref_mem[st_addr[MEM_AW+2:3]] = src2;
      end
      ref_pc  = exp_next;
      retired = retired + 1;
    end
  end

  task automatic value_mismatch(input string name, input logic [XLEN-1:0] got,
      input logic [XLEN-1:0] expected);
    mismatches++;
    $display("ERROR %0t ns %s got %h expected %h", $time, name, got, expected);
  endtask

  task automatic protocol_error(input string what);
    protocol_errors++;
    $display("%0t ns: %s", $time, what);
  endtask

  retire_pc_check: assert property (@(posedge clk) disable iff (rst)
      retire_valid |-> retire.pc == ref_pc)
    else value_mismatch("o_retire.pc", $sampled(retire.pc), $sampled(ref_pc));

  retire_wen_check: assert property (@(posedge clk) disable iff (rst)
      retire_valid |-> retire.rd_wen == exp_wen)
    else value_mismatch("o_retire.rd_wen", 64'($sampled(retire.rd_wen)), 64'($sampled(exp_wen)));

  retire_rd_check: assert property (@(posedge clk) disable iff (rst)
      retire_valid && exp_wen |-> retire.rd == inst[11:7])
    else value_mismatch("o_retire.rd", 64'($sampled(retire.rd)), 64'($sampled(inst[11:7])));

  retire_data_check: assert property (@(posedge clk) disable iff (rst)
      retire_valid && exp_wen |-> retire.wdata == exp_val)
    else value_mismatch("o_retire.wdata", $sampled(retire.wdata), $sampled(exp_val));

  store_only_check: assert property (@(posedge clk) disable iff (rst)
      bus_req && bus_ack && bus.we |-> exp_store)
    else protocol_error("bus write issued while the current instruction is not SD");

  store_addr_check: assert property (@(posedge clk) disable iff (rst)
      bus_req && bus_ack && bus.we |-> bus.addr == st_addr)
    else value_mismatch("o_bus.addr", $sampled(bus.addr), $sampled(st_addr));

  store_data_check: assert property (@(posedge clk) disable iff (rst)
      bus_req && bus_ack && bus.we |-> bus.wdata == src2)
    else value_mismatch("o_bus.wdata", $sampled(bus.wdata), $sampled(src2));

  req_hold_check: assert property (@(posedge clk) disable iff (rst)
      bus_req && !bus_ack |=> bus_req)
    else protocol_error("o_bus_req dropped before i_bus_ack arrived");

  req_stable_check: assert property (@(posedge clk) disable iff (rst)
      bus_req && !bus_ack |=> $stable(bus))
    else protocol_error("o_bus changed while waiting for i_bus_ack");

  task automatic report_and_finish(input logic timed_out);
    $display("retired %0d, value mismatches %0d, protocol errors %0d",
             retired, mismatches, protocol_errors);
    if (!timed_out && mismatches == 0 && protocol_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(24));
    build_image();
    for (int w = 0; w < 2**MEM_AW; w++) begin
      u_mem.preload(w[MEM_AW-1:0], image[w]);
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    wait (retired == NUM_RETIRE);
    @(negedge clk);
    report_and_finish(1'b0);
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns with %0d of %0d instructions retired",
             TIMEOUT_NS, retired, NUM_RETIRE);
    report_and_finish(1'b1);
  end

endmodule

`default_nettype wire

/* tb/tb_mem_model.sv */
// Bus memory model
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
  parameter int AW = 8
) (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire                              i_bus_req,
  input  wire  rv_core_pkg::bus_req_t      i_bus,
  output logic                             o_bus_ack,
  output logic [rv_core_pkg::XLEN-1:0]     o_bus_rdata
);
  import rv_core_pkg::*;

  localparam int MAX_DELAY = 3;

  logic [XLEN-1:0] mem [2**AW];
  logic [AW-1:0]   idx;
  logic            ack = 1'b0;
  logic [XLEN-1:0] rdata = '0;
  logic            pending = 1'b0;
  int unsigned     delay = 0;

  assign idx         = i_bus.addr[AW+2:3];
  assign o_bus_ack   = ack;
  assign o_bus_rdata = rdata;

  task automatic preload(input logic [AW-1:0] index, input logic [XLEN-1:0] data);
    mem[index] = data;
  endtask

  // answers on the falling edge, random wait of 0 to 3 cycles per access
  always @(negedge clk) begin
    if (i_rst) begin
      ack     <= 1'b0;
      rdata   <= '0;
      pending = 1'b0;
      delay   = 0;
    end else if (ack) begin
      ack <= 1'b0;
    end else if (i_bus_req) begin
      if (!pending) begin
        pending = 1'b1;
        delay   = $urandom_range(MAX_DELAY, 0);
      end
      if (delay == 0) begin
        pending = 1'b0;
        ack     <= 1'b1;
        if (i_bus.we) begin
          mem[idx] = i_bus.wdata;
          rdata    <= '0;
        end else begin
          rdata <= mem[idx];
        end
      end else begin
        delay = delay - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/rv_core.sv */
// Multi-cycle RV64I core
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  wire                              clk,
  input  wire                              i_rst,
  output logic                             o_bus_req,
  output rv_core_pkg::bus_req_t            o_bus,
  input  wire                              i_bus_ack,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_bus_rdata,
  output logic                             o_retire_valid,
  output rv_core_pkg::retire_t             o_retire
);
  import rv_core_pkg::*;

  // stage strobes and payloads
  logic fetched, decoded, executed, memoryed, done;
  logic [XLEN-1:0]   if_pc;
  logic [ILEN-1:0]   if_inst;
  dec_t              dec;
  exe_t              exe;
  wb_t               wb;
  logic              jmp;
  logic [XLEN-1:0]   jmp_addr;

  // register file ports
  logic [RIDX_W-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]   rs1_data, rs2_data, rd_wdata;
  logic              rd_wen;

  // arbiter side of the bus
  logic              if_req, if_ack, mem_req, mem_ack;
  bus_req_t          if_bus, mem_bus;
  logic [XLEN-1:0]   arb_rdata;

  fetch_stage u_fetch (
    .clk(clk), .i_rst(i_rst), .i_done(done), .i_jmp(jmp), .i_jmp_addr(jmp_addr),
    .o_bus_req(if_req), .o_bus(if_bus), .i_bus_ack(if_ack), .i_bus_rdata(arb_rdata),
    .o_fetched(fetched), .o_pc(if_pc), .o_inst(if_inst));

  decode_stage u_decode (
    .clk(clk), .i_rst(i_rst), .i_fetched(fetched), .i_pc(if_pc), .i_inst(if_inst),
    .o_rs1(rs1), .o_rs2(rs2), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_decoded(decoded), .o_dec(dec));

  execute_stage u_execute (
    .clk(clk), .i_rst(i_rst), .i_decoded(decoded), .i_dec(dec), .o_executed(executed),
    .o_exe(exe), .o_jmp(jmp), .o_jmp_addr(jmp_addr));

  memory_stage u_memory (
    .clk(clk), .i_rst(i_rst), .i_executed(executed), .i_exe(exe),
    .o_bus_req(mem_req), .o_bus(mem_bus), .i_bus_ack(mem_ack), .i_bus_rdata(arb_rdata),
    .o_memoryed(memoryed), .o_wb(wb));

  writeback_stage u_writeback (
    .clk(clk), .i_rst(i_rst), .i_memoryed(memoryed), .i_wb(wb), .o_rd(rd),
    .o_rd_wen(rd_wen), .o_rd_wdata(rd_wdata), .o_done(done),
    .o_retire_valid(o_retire_valid), .o_retire(o_retire));

  reg_file u_reg_file (
    .clk(clk), .i_rst(i_rst), .i_rs1(rs1), .i_rs2(rs2), .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data), .i_rd(rd), .i_rd_wen(rd_wen), .i_rd_wdata(rd_wdata));

  mem_arbiter u_arbiter (
    .clk(clk), .i_rst(i_rst), .i_if_req(if_req), .i_if_bus(if_bus), .o_if_ack(if_ack),
    .i_mem_req(mem_req), .i_mem_bus(mem_bus), .o_mem_ack(mem_ack), .o_rdata(arb_rdata),
    .o_bus_req(o_bus_req), .o_bus(o_bus), .i_bus_ack(i_bus_ack),
    .i_bus_rdata(i_bus_rdata));

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
// Shared bus arbiter
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire                              i_if_req,
  input  wire  rv_core_pkg::bus_req_t      i_if_bus,
  output logic                             o_if_ack,
  input  wire                              i_mem_req,
  input  wire  rv_core_pkg::bus_req_t      i_mem_bus,
  output logic                             o_mem_ack,
  output logic [rv_core_pkg::XLEN-1:0]     o_rdata,
  output logic                             o_bus_req,
  output rv_core_pkg::bus_req_t            o_bus,
  input  wire                              i_bus_ack,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_bus_rdata
);
  import rv_core_pkg::*;

  typedef enum logic {OWN_IF, OWN_MEM} owner_e;

  owner_e owner_q;
  owner_e owner;
  logic   busy;

  // requesters never overlap, so any active one may take the bus
  assign owner     = busy ? owner_q : (i_mem_req ? OWN_MEM : OWN_IF);
  assign o_bus_req = (owner == OWN_MEM) ? i_mem_req : i_if_req;
  assign o_bus     = (owner == OWN_MEM) ? i_mem_bus : i_if_bus;
  assign o_if_ack  = i_bus_ack && (owner == OWN_IF);
  assign o_mem_ack = i_bus_ack && (owner == OWN_MEM);
  assign o_rdata   = i_bus_rdata;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy    <= 1'b0;
      owner_q <= OWN_IF;
    end else begin
      owner_q <= owner;
      busy    <= o_bus_req && !i_bus_ack;
    end
  end

endmodule

`default_nettype wire

/* source/reg_file.sv */
// Integer register file
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire  [rv_core_pkg::RIDX_W-1:0]   i_rs1,
  input  wire  [rv_core_pkg::RIDX_W-1:0]   i_rs2,
  output logic [rv_core_pkg::XLEN-1:0]     o_rs1_data,
  output logic [rv_core_pkg::XLEN-1:0]     o_rs2_data,
  input  wire  [rv_core_pkg::RIDX_W-1:0]   i_rd,
  input  wire                              i_rd_wen,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_rd_wdata
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] regs [1 << RIDX_W];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < (1 << RIDX_W); i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && i_rd != '0) begin
      regs[i_rd] <= i_rd_wdata;
    end
  end

  // x0 always reads zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

/* source/writeback_stage.sv */
// Register writeback and retire
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire                              i_memoryed,
  input  wire  rv_core_pkg::wb_t           i_wb,
  output logic [rv_core_pkg::RIDX_W-1:0]   o_rd,
  output logic                             o_rd_wen,
  output logic [rv_core_pkg::XLEN-1:0]     o_rd_wdata,
  output logic                             o_done,
  output logic                             o_retire_valid,
  output rv_core_pkg::retire_t             o_retire
);
  import rv_core_pkg::*;

  wb_t  rec;
  logic pulse;

  always_ff @(posedge clk) begin
    if (i_rst) pulse <= 1'b0;
    else pulse <= i_memoryed;
  end

  always_ff @(posedge clk) begin
    if (i_memoryed) rec <= i_wb;
  end

  // regfile write, retire and done share the same cycle
  assign o_rd           = rec.rd;
  assign o_rd_wen       = pulse && rec.rd_wen;
  assign o_rd_wdata     = rec.wdata;
  assign o_done         = pulse;
  assign o_retire_valid = pulse;
  assign o_retire       = '{pc: rec.pc, rd: rec.rd, rd_wen: rec.rd_wen, wdata: rec.wdata};

endmodule

`default_nettype wire

/* source/memory_stage.sv */
// Load and store access
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire                              i_executed,
  input  wire  rv_core_pkg::exe_t          i_exe,
  output logic                             o_bus_req,
  output rv_core_pkg::bus_req_t            o_bus,
  input  wire                              i_bus_ack,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_bus_rdata,
  output logic                             o_memoryed,
  output rv_core_pkg::wb_t                 o_wb
);
  import rv_core_pkg::*;

  typedef enum logic {MS_IDLE, MS_WAIT} mstate_e;

  mstate_e state;
  logic    is_mem;

  assign is_mem = (i_exe.op == OP_LD) || (i_exe.op == OP_SD);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state      <= MS_IDLE;
      o_bus_req  <= 1'b0;
      o_memoryed <= 1'b0;
    end else begin
      o_memoryed <= 1'b0;
      case (state)
        MS_IDLE: if (i_executed) begin
          if (is_mem) begin
            state     <= MS_WAIT;
            o_bus_req <= 1'b1;
          end else begin
            o_memoryed <= 1'b1;
          end
        end
        MS_WAIT: if (i_bus_ack) begin
          state      <= MS_IDLE;
          o_bus_req  <= 1'b0;
          o_memoryed <= 1'b1;
        end
        default: state <= MS_IDLE;
      endcase
    end
  end

  // execute payload holds steady while the access is outstanding
  always_ff @(posedge clk) begin
    if (state == MS_IDLE && i_executed) begin
      o_bus <= '{we: i_exe.op == OP_SD, addr: i_exe.addr, wdata: i_exe.sdata};
      o_wb  <= '{pc: i_exe.pc, rd: i_exe.rd, rd_wen: i_exe.rd_wen, wdata: i_exe.result};
    end else if (state == MS_WAIT && i_bus_ack && i_exe.op == OP_LD) begin
      o_wb.wdata <= i_bus_rdata;
    end
  end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// Integer execute
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire                              i_decoded,
  input  wire  rv_core_pkg::dec_t          i_dec,
  output logic                             o_executed,
  output rv_core_pkg::exe_t                o_exe,
  output logic                             o_jmp,
  output logic [rv_core_pkg::XLEN-1:0]     o_jmp_addr
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] result;
  logic            taken;

  always_comb begin
    case (i_dec.op)
      OP_ADD:  result = i_dec.op1 + i_dec.op2;
      OP_SUB:  result = i_dec.op1 - i_dec.op2;
      OP_AND:  result = i_dec.op1 & i_dec.op2;
      OP_OR:   result = i_dec.op1 | i_dec.op2;
      OP_XOR:  result = i_dec.op1 ^ i_dec.op2;
      OP_LUI:  result = i_dec.imm;
      // link value
      OP_JAL:  result = i_dec.pc + XLEN'(4);
      default: result = '0;
    endcase
  end

  assign taken = (i_dec.op == OP_JAL) ||
                 (i_dec.op == OP_BEQ && i_dec.op1 == i_dec.op2) ||
                 (i_dec.op == OP_BNE && i_dec.op1 != i_dec.op2);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_executed <= 1'b0;
      o_jmp      <= 1'b0;
    end else begin
      o_executed <= i_decoded;
      if (i_decoded) o_jmp <= taken;
    end
  end

  always_ff @(posedge clk) begin
    if (i_decoded) begin
      o_exe      <= '{pc: i_dec.pc, op: i_dec.op, rd: i_dec.rd, rd_wen: i_dec.rd_wen,
                      result: result, addr: i_dec.op1 + i_dec.imm, sdata: i_dec.op2};
      o_jmp_addr <= i_dec.pc + i_dec.imm;
    end
  end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// Instruction decode
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire                              i_fetched,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_pc,
  input  wire  [rv_core_pkg::ILEN-1:0]     i_inst,
  output logic [rv_core_pkg::RIDX_W-1:0]   o_rs1,
  output logic [rv_core_pkg::RIDX_W-1:0]   o_rs2,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_rs1_data,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_rs2_data,
  output logic                             o_decoded,
  output rv_core_pkg::dec_t                o_dec
);
  import rv_core_pkg::*;

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [RIDX_W-1:0] rd;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_s;
  logic [XLEN-1:0]   imm_b;
  logic [XLEN-1:0]   imm_j;
  logic [XLEN-1:0]   imm_u;
  op_e               op;
  logic [XLEN-1:0]   imm;
  logic              use_imm;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rd     = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};

  always_comb begin
    op      = OP_NOP;
    imm     = imm_i;
    use_imm = 1'b0;
    case (opcode)
      7'b0010011: if (funct3 == 3'b000) begin
        op      = OP_ADD;
        use_imm = 1'b1;
      end
      7'b0110011: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = OP_ADD;
            3'b100:  op = OP_XOR;
            3'b110:  op = OP_OR;
            3'b111:  op = OP_AND;
            default: op = OP_NOP;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = OP_SUB;
        end
      end
      7'b0110111: begin
        op  = OP_LUI;
        imm = imm_u;
      end
      7'b0000011: if (funct3 == 3'b011) op = OP_LD;
      7'b0100011: if (funct3 == 3'b011) begin
        op  = OP_SD;
        imm = imm_s;
      end
      7'b1100011: begin
        imm = imm_b;
        if (funct3 == 3'b000) op = OP_BEQ;
        else if (funct3 == 3'b001) op = OP_BNE;
      end
      7'b1101111: begin
        op  = OP_JAL;
        imm = imm_j;
      end
      default: op = OP_NOP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_decoded <= 1'b0;
    end else begin
      o_decoded <= i_fetched;
    end
  end

  // no write for stores, branches, no-ops, or rd of x0
  always_ff @(posedge clk) begin
    if (i_fetched) begin
      o_dec.pc     <= i_pc;
      o_dec.op     <= op;
      o_dec.rd     <= rd;
      o_dec.rd_wen <= (rd != '0) && !(op inside {OP_SD, OP_BEQ, OP_BNE, OP_NOP});
      o_dec.op1    <= i_rs1_data;
      o_dec.op2    <= use_imm ? imm : i_rs2_data;
      o_dec.imm    <= imm;
    end
  end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
// Instruction fetch
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  wire                              clk,
  input  wire                              i_rst,
  input  wire                              i_done,
  input  wire                              i_jmp,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_jmp_addr,
  output logic                             o_bus_req,
  output rv_core_pkg::bus_req_t            o_bus,
  input  wire                              i_bus_ack,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_bus_rdata,
  output logic                             o_fetched,
  output logic [rv_core_pkg::XLEN-1:0]     o_pc,
  output logic [rv_core_pkg::ILEN-1:0]     o_inst
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] pc;
  logic            boot;

  // word-aligned read of the doubleword holding pc
  assign o_bus = '{we: 1'b0, addr: {pc[XLEN-1:3], 3'b000}, wdata: '0};

  always_ff @(posedge clk) begin
    if (i_rst) begin
      pc        <= RESET_PC;
      boot      <= 1'b1;
      o_bus_req <= 1'b0;
      o_fetched <= 1'b0;
    end else begin
      o_fetched <= 1'b0;
      if (boot) begin
        boot      <= 1'b0;
        o_bus_req <= 1'b1;
      end else if (i_done) begin
        pc        <= i_jmp ? i_jmp_addr : pc + XLEN'(4);
        o_bus_req <= 1'b1;
      end else if (o_bus_req && i_bus_ack) begin
        o_bus_req <= 1'b0;
        o_fetched <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_bus_req && i_bus_ack) begin
      o_pc   <= pc;
      o_inst <= pc[2] ? i_bus_rdata[63:32] : i_bus_rdata[31:0];
    end
  end

endmodule

`default_nettype wire

/* source/rv_core_pkg.sv */
// RV64I core shared definitions
`default_nettype none

package rv_core_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;
  localparam int RIDX_W = 5;
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // kept operations, anything else decodes to OP_NOP
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LUI,
    OP_LD,
    OP_SD,
    OP_BEQ,
    OP_BNE,
    OP_JAL,
    OP_NOP
  } op_e;

  typedef struct packed {
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    op_e               op;
    logic [RIDX_W-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   imm;
  } dec_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    op_e               op;
    logic [RIDX_W-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   sdata;
  } exe_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [RIDX_W-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   wdata;
  } wb_t;

  // outward-facing copy of the writeback record
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [RIDX_W-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   wdata;
  } retire_t;

endpackage

`default_nettype wire
